//--- hdl/bdiPkg.sv
`default_nettype none

package bdiPkg;

    localparam int LineBits = 256;
    localparam int NumEncodings = 6;

    // Raw line, or compressed line padded with zeros
    typedef logic [LineBits-1:0] cacheLineT;

    // Listed in order of compressed size, ties resolved by position
    typedef enum logic [2:0] {
        base8Delta1,
        base4Delta1,
        base8Delta2,
        base2Delta1,
        base4Delta2,
        base8Delta4,
        uncompressed
    } encodingE;

    // Uncompressed is treated as one base word spanning the whole line
    function automatic int baseBytesOf(encodingE enc);
        case (enc)
            base8Delta1, base8Delta2, base8Delta4: return 8;
            base4Delta1, base4Delta2: return 4;
            base2Delta1: return 2;
            default: return LineBits / 8;
        endcase
    endfunction

    function automatic int deltaBytesOf(encodingE enc);
        case (enc)
            base8Delta1, base4Delta1, base2Delta1: return 1;
            base8Delta2, base4Delta2: return 2;
            base8Delta4: return 4;
            default: return 0;
        endcase
    endfunction

    function automatic int compressedBits(encodingE enc);
        int words;
        words = LineBits / (8 * baseBytesOf(enc));
        return 8 * baseBytesOf(enc) + 8 * deltaBytesOf(enc) * words;
    endfunction

endpackage

`default_nettype wire

//--- hdl/candidateIf.sv
`default_nettype none

interface candidateIf
    import bdiPkg::*;
();

    logic valid;
    cacheLineT line;

    // One entry per compressed encoding, indexed by encodingE value
    logic [NumEncodings-1:0] fits;
    cacheLineT payload [NumEncodings];

    modport stage (
        output valid,
        output line,
        output fits,
        output payload
    );

    modport select (
        input valid,
        input line,
        input fits,
        input payload
    );

endinterface

`default_nettype wire

//--- hdl/deltaEncoder.sv
`default_nettype none

module deltaEncoder
    import bdiPkg::*;
#(
    parameter int baseBytes = 8,
    parameter int deltaBytes = 1
)(
    input  cacheLineT line,
    output logic      fits,
    output cacheLineT payload
);

    localparam int WordBits = 8 * baseBytes;
    localparam int DeltaBits = 8 * deltaBytes;
    localparam int NumWords = LineBits / WordBits;

    logic [WordBits-1:0] base;
    logic [WordBits-1:0] diff [NumWords];
    logic [NumWords-1:0] wordFits;

    assign base = line[WordBits-1:0];

    for (genvar w = 0; w < NumWords; w++)
    begin : gWord
        // Wraps modulo the word width
        assign diff[w] = line[w*WordBits +: WordBits] - base;
        assign wordFits[w] = diff[w] ==
            {{(WordBits-DeltaBits){diff[w][DeltaBits-1]}}, diff[w][DeltaBits-1:0]};
    end

    assign fits = &wordFits;

    always_comb
    begin
        payload = '0;
        payload[WordBits-1:0] = base;
        // Slot 0 stays zero
        for (int w = 1; w < NumWords; w++)
        begin
            payload[WordBits + DeltaBits*w +: DeltaBits] = diff[w][DeltaBits-1:0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/deltaStage.sv
`default_nettype none

module deltaStage
    import bdiPkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      lineValid,
    input  cacheLineT lineIn,
    candidateIf.stage candidates
);

    logic [NumEncodings-1:0] fitsNext;
    cacheLineT payloadNext [NumEncodings];

    // One checker per compressed encoding
    for (genvar e = 0; e < NumEncodings; e++)
    begin : gEncoder
        deltaEncoder #(
            .baseBytes (baseBytesOf(encodingE'(e))),
            .deltaBytes(deltaBytesOf(encodingE'(e)))
        ) i_deltaEncoder (
            .line   (lineIn),
            .fits   (fitsNext[e]),
            .payload(payloadNext[e])
        );
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            candidates.valid <= 1'b0;
        end
        else
        begin
            candidates.valid <= lineValid;
        end
    end

    // Candidates hold until the next line arrives
    always_ff @(posedge clock)
    begin
        if (lineValid)
        begin
            candidates.line <= lineIn;
            candidates.fits <= fitsNext;
            candidates.payload <= payloadNext;
        end
    end

endmodule

`default_nettype wire

//--- hdl/encodingSelect.sv
`default_nettype none

module encodingSelect
    import bdiPkg::*;
(
    input  logic       clock,
    input  logic       reset,
    candidateIf.select candidates,
    output logic       compValid,
    output encodingE   compEncoding,
    output cacheLineT  compLine
);

    logic found;
    encodingE bestEncoding;
    cacheLineT bestLine;

    // Enum order is by size, so the first fit is the smallest
    always_comb
    begin
        found = 1'b0;
        bestEncoding = uncompressed;
        bestLine = candidates.line;
        for (int e = 0; e < NumEncodings; e++)
        begin
            if (!found && candidates.fits[e])
            begin
                found = 1'b1;
                bestEncoding = encodingE'(e);
                bestLine = candidates.payload[e];
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            compValid <= 1'b0;
        end
        else
        begin
            compValid <= candidates.valid;
        end
    end

    always_ff @(posedge clock)
    begin
        if (candidates.valid)
        begin
            compEncoding <= bestEncoding;
            compLine <= bestLine;
        end
    end

    // Fallback must carry the line stage 1 registered
    assert property (@(posedge clock) disable iff (reset)
        compValid && compEncoding == uncompressed |-> compLine == $past(candidates.line))
        else $error("uncompressed result differs from original line");

    assert property (@(posedge clock) disable iff (reset)
        compValid |-> (compLine >> compressedBits(compEncoding)) == '0)
        else $error("compressed line wider than encoding %s", compEncoding.name());

endmodule

`default_nettype wire

//--- hdl/lineDecompressor.sv
`default_nettype none

module lineDecompressor
    import bdiPkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      compValid,
    input  encodingE  compEncoding,
    input  cacheLineT compLine,
    output logic      decompValid,
    output cacheLineT decompLine
);

    cacheLineT rebuilt [NumEncodings];
    cacheLineT lineNext;

    // Every geometry is rebuilt in parallel and the encoding picks one
    for (genvar e = 0; e < NumEncodings; e++)
    begin : gRebuild
        localparam int WordBits = 8 * baseBytesOf(encodingE'(e));
        localparam int DeltaBits = 8 * deltaBytesOf(encodingE'(e));
        localparam int NumWords = LineBits / WordBits;

        cacheLineT words;

        always_comb
        begin
            logic [WordBits-1:0] base;
            logic [DeltaBits-1:0] delta;
            base = compLine[WordBits-1:0];
            // Slot 0 is zero so word 0 comes out as the base
            for (int w = 0; w < NumWords; w++)
            begin
                delta = compLine[WordBits + DeltaBits*w +: DeltaBits];
                words[w*WordBits +: WordBits] =
                    base + {{(WordBits-DeltaBits){delta[DeltaBits-1]}}, delta};
            end
        end

        assign rebuilt[e] = words;

        // Word 0 relies on an empty delta slot 0
        assert property (@(posedge clock) disable iff (reset)
            compValid && compEncoding == encodingE'(e)
                |-> compLine[WordBits +: DeltaBits] == '0)
            else $error("delta slot 0 not zero for %s", compEncoding.name());
    end

    always_comb
    begin
        if (compEncoding == uncompressed)
        begin
            lineNext = compLine;
        end
        else
        begin
            lineNext = rebuilt[compEncoding];
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            decompValid <= 1'b0;
        end
        else
        begin
            decompValid <= compValid;
        end
    end

    always_ff @(posedge clock)
    begin
        if (compValid)
        begin
            decompLine <= lineNext;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bdiCompressor.sv
`default_nettype none

module bdiCompressor
    import bdiPkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      lineValid,
    input  cacheLineT lineIn,
    output logic      compValid,
    output encodingE  compEncoding,
    output cacheLineT compLine,
    output logic      decompValid,
    output cacheLineT decompLine
);

    candidateIf candidates ();

    // Stage 1 finds which encodings fit
    deltaStage i_deltaStage (
        .clock     (clock),
        .reset     (reset),
        .lineValid (lineValid),
        .lineIn    (lineIn),
        .candidates(candidates.stage)
    );

    // Stage 2 keeps the smallest
    encodingSelect i_encodingSelect (
        .clock       (clock),
        .reset       (reset),
        .candidates  (candidates.select),
        .compValid   (compValid),
        .compEncoding(compEncoding),
        .compLine    (compLine)
    );

    // Stage 3 rebuilds the line from the compressed form alone
    lineDecompressor i_lineDecompressor (
        .clock       (clock),
        .reset       (reset),
        .compValid   (compValid),
        .compEncoding(compEncoding),
        .compLine    (compLine),
        .decompValid (decompValid),
        .decompLine  (decompLine)
    );

endmodule

`default_nettype wire

//--- tests/bdiModel.svh
`ifndef BDI_MODEL_SVH
`define BDI_MODEL_SVH

// Mask of the low n bytes for n from 1 to 8
function automatic logic [63:0] byteMask(int bytes);
    return (64'd1 << (8 * bytes)) - 64'd1;
endfunction

function automatic logic [63:0] wordAt(cacheLineT line, int bytes, int index);
    return 64'(line >> (8 * bytes * index)) & byteMask(bytes);
endfunction

function automatic logic [63:0] signExtend(logic [63:0] value, int fromBytes, int toBytes);
    logic [63:0] low;
    low = value & byteMask(fromBytes);
    if (low[8 * fromBytes - 1])
        low = low | ~byteMask(fromBytes);
    return low & byteMask(toBytes);
endfunction

// Word minus base wrapped to the word width
function automatic logic [63:0] deltaOf(cacheLineT line, int bytes, int index);
    return (wordAt(line, bytes, index) - wordAt(line, bytes, 0)) & byteMask(bytes);
endfunction

function automatic bit encodingFits(cacheLineT line, encodingE enc);
    int wb;
    int db;
    wb = baseBytesOf(enc);
    db = deltaBytesOf(enc);
    for (int i = 1; i < 32 / wb; i++)
    begin
        if (signExtend(deltaOf(line, wb, i), db, wb) != deltaOf(line, wb, i))
            return 1'b0;
    end
    return 1'b1;
endfunction

function automatic int sizeInBits(encodingE enc);
    if (enc == uncompressed)
        return 256;
    return 8 * baseBytesOf(enc) + 8 * deltaBytesOf(enc) * (32 / baseBytesOf(enc));
endfunction

// Smallest fitting size with the earlier encoding winning ties
function automatic encodingE smallestEncoding(cacheLineT line);
    encodingE best;
    best = uncompressed;
    for (int e = 0; e < NumEncodings; e++)
    begin
        if (encodingFits(line, encodingE'(e)) && sizeInBits(encodingE'(e)) < sizeInBits(best))
            best = encodingE'(e);
    end
    return best;
endfunction

function automatic cacheLineT packLine(cacheLineT line, encodingE enc);
    cacheLineT result;
    int wb;
    int db;
    if (enc == uncompressed)
        return line;
    wb = baseBytesOf(enc);
    db = deltaBytesOf(enc);
    result = cacheLineT'(wordAt(line, wb, 0));
    for (int i = 1; i < 32 / wb; i++)
    begin
        result |= cacheLineT'(deltaOf(line, wb, i) & byteMask(db)) << (8 * wb + 8 * db * i);
    end
    return result;
endfunction

`endif

//--- tests/bdiCompressorTb.sv
`default_nettype none

module bdiCompressorTb
    import bdiPkg::*;
();

    localparam int Timeout = 50;

    logic clock;
    logic reset;
    logic lineValid;
    cacheLineT lineIn;
    logic compValid;
    encodingE compEncoding;
    cacheLineT compLine;
    logic decompValid;
    cacheLineT decompLine;

    int cycle = 0;
    int errors = 0;
    int timeouts = 0;

    `include "bdiModel.svh"

    bdiCompressor i_bdiCompressor (
        .clock       (clock),
        .reset       (reset),
        .lineValid   (lineValid),
        .lineIn      (lineIn),
        .compValid   (compValid),
        .compEncoding(compEncoding),
        .compLine    (compLine),
        .decompValid (decompValid),
        .decompLine  (decompLine)
    );

    initial
    begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock)
    begin
        cycle <= cycle + 1;
    end

    task automatic compareValue(string testName, string what, cacheLineT expected,
                                cacheLineT actual);
        assert (actual == expected)
        else
        begin
            $display("ERR %s %s: expected %0h actual %0h", testName, what, expected, actual);
            errors++;
        end
    endtask

    task automatic matchEncoding(string testName, encodingE expected, encodingE actual);
        assert (actual == expected)
        else
        begin
            $display("ERR %s compEncoding: expected %s actual %s",
                     testName, expected.name(), actual.name());
            errors++;
        end
    endtask

    task automatic idleStrobes(string testName, int cycles);
        repeat (cycles)
        begin
            @(negedge clock);
            assert (!compValid && !decompValid)
            else
            begin
                $display("%s: output strobe high with no line in flight", testName);
                errors++;
            end
        end
    endtask

    // Results on one output strobe arrive in input order
    task automatic collect(string testName, cacheLineT lines[$], int startCycle, bit rebuilt);
        int got;
        int waited;
        encodingE enc;
        got = 0;
        waited = 0;
        while (got < lines.size() && waited < Timeout)
        begin
            @(negedge clock);
            waited++;
            if (rebuilt ? decompValid : compValid)
            begin
                compareValue(testName, "latency", cacheLineT'((rebuilt ? 3 : 2) + got),
                             cacheLineT'(cycle - startCycle));
                if (rebuilt)
                begin
                    compareValue(testName, "decompLine", lines[got], decompLine);
                end
                else
                begin
                    enc = smallestEncoding(lines[got]);
                    matchEncoding(testName, enc, compEncoding);
                    compareValue(testName, "compLine", packLine(lines[got], enc), compLine);
                end
                got++;
            end
        end
        if (got < lines.size())
        begin
            $display("%s: timed out waiting for %s", testName,
                     rebuilt ? "decompValid" : "compValid");
            timeouts++;
        end
    endtask

    // Lines go in back to back
    task automatic sendLines(string testName, cacheLineT lines[$]);
        int startCycle;
        @(negedge clock);
        startCycle = cycle;
        fork
            begin
                foreach (lines[i])
                begin
                    lineValid = 1'b1;
                    lineIn = lines[i];
                    @(negedge clock);
                end
                lineValid = 1'b0;
            end
            collect(testName, lines, startCycle, 1'b0);
            collect(testName, lines, startCycle, 1'b1);
        join
    endtask

    task automatic compressOne(string testName, cacheLineT line, encodingE wantEnc);
        cacheLineT lines[$];
        assert (smallestEncoding(line) == wantEnc)
        else
        begin
            $display("%s: stimulus line does not select %s", testName, wantEnc.name());
            errors++;
        end
        lines.push_back(line);
        sendLines(testName, lines);
    endtask

    function automatic cacheLineT buildLine(int wordBytes, logic [63:0] base, longint deltas[$]);
        cacheLineT line;
        logic [63:0] word;
        line = '0;
        foreach (deltas[i])
        begin
            word = (base + deltas[i]) & byteMask(wordBytes);
            line |= cacheLineT'(word) << (8 * wordBytes * i);
        end
        return line;
    endfunction

    function automatic cacheLineT randomLine();
        cacheLineT line;
        line = '0;
        repeat (8)
        begin
            line = {line[223:0], $urandom()};
        end
        return line;
    endfunction

    task automatic base8Encodings();
        longint d[$];
        d = '{0, 5, -3, 127};
        compressOne("base8Delta1", buildLine(8, 64'h0123_4567_89ab_cdef, d), base8Delta1);
        d = '{0, 300, -1000, 32767};
        compressOne("base8Delta2", buildLine(8, 64'h0123_4567_89ab_cdef, d), base8Delta2);
        d = '{0, 70000, -1000000, 2000000000};
        compressOne("base8Delta4", buildLine(8, 64'h0123_4567_89ab_cdef, d), base8Delta4);
    endtask

    task automatic narrowEncodings();
        longint d[$];
        d = '{0, 1, 2, 3, -4, 5, -6, 7};
        compressOne("base4Delta1", buildLine(4, 64'h1234_5678, d), base4Delta1);
        d = '{0, 1000, -2000, 30000, -30000, 5, 6, 7};
        compressOne("base4Delta2", buildLine(4, 64'h1234_5678, d), base4Delta2);
        d = '{0, 3, -7, 12, -20, 25, -33, 40, -48, 55, -61, 70, -80, 90, -100, 120};
        compressOne("base2Delta1", buildLine(2, 64'h4321, d), base2Delta1);
        // Both 96-bit encodings fit a constant line
        compressOne("tie", {32{8'hab}}, base8Delta1);
    endtask

    task automatic fallbackLines();
        cacheLineT line;
        repeat (3)
        begin
            line = randomLine();
            repeat (10)
            begin
                if (smallestEncoding(line) != uncompressed)
                    line = randomLine();
            end
            compressOne("uncompressed", line, uncompressed);
        end
    endtask

    task automatic streamEight();
        cacheLineT lines[$];
        longint d[$];
        d = '{0, -1, -128, 127};
        lines.push_back(buildLine(8, 64'hffff_ffff_ffff_fff0, d));
        d = '{0, -30000, 2, 32767, -32768, 1, -1, 0};
        lines.push_back(buildLine(4, 64'h0000_0010, d));
        lines.push_back({32{8'h5a}});
        d = '{0, -1000000, 1, -2000000000};
        lines.push_back(buildLine(8, 64'h8000_0000_0000_0000, d));
        repeat (4)
        begin
            lines.push_back(randomLine());
        end
        sendLines("streaming", lines);
        idleStrobes("streaming drained", 4);
    endtask

    initial
    begin
        void'($urandom(32'hc61a));
        reset = 1'b1;
        lineValid = 1'b0;
        lineIn = '0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        idleStrobes("after reset", 4);
        base8Encodings();
        narrowEncodings();
        fallbackLines();
        streamEight();
        $display("Failed checks: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+tests
hdl/bdiPkg.sv
hdl/candidateIf.sv
hdl/deltaEncoder.sv
hdl/deltaStage.sv
hdl/encodingSelect.sv
hdl/lineDecompressor.sv
hdl/bdiCompressor.sv
tests/bdiCompressorTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f files.f --top-module bdiCompressorTb -Mdir obj_dir \
    && ./obj_dir/VbdiCompressorTb > sim.log \
    ; cat sim.log 2>/dev/null \
    ; grep -q "TB PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
